// File: core_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "pr_macros.svh"

module core_ctrl import pr_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  core_reset,

  input  desc_t                 desc,
  input  logic                  desc_valid,
  output logic                  desc_ready,

  input  logic                  dma_rd_valid,
  input  logic [`PR_ADDR_W-1:0] dma_rd_addr,
  output logic                  dma_rd_ready,

  output logic                  resp_valid,
  output logic [`PR_DATA_W-1:0] resp_data,
  input  logic                  resp_ready,

  output logic                  csum_clear,
  output logic                  csum_acc,
  output logic [`PR_DATA_W-1:0] csum_word,
  input  logic [31:0]           csum,

  output out_desc_t             odesc,
  output logic                  odesc_valid,
  input  logic                  odesc_ready,

  mem_rd_if.ctrl                rd
);

  typedef enum logic [1:0] {
    st_idle,
    st_reading,
    st_draining,
    st_emitting
  } state_e;

  state_e                state;
  desc_t                 cur;
  logic [`PR_ADDR_W-1:0] issue_addr;
  logic [`PR_LEN_W-1:0]  issue_left;
  logic [`PR_LEN_W-1:0]  ret_left;
  logic [1:0]            inflight;
  logic                  last_core;
  logic                  core_reset_seen;
  logic                  core_pend;
  logic                  grant_core;
  logic                  core_issue;
  logic                  core_ret;
  logic                  desc_fire;

  //////////////////////////////
  // Read arbitration, alternates when both pend
  assign core_pend    = (state == st_reading);
  assign grant_core   = core_pend && !(dma_rd_valid && last_core);
  assign dma_rd_ready = rd.req_ready && (!core_pend || last_core);

  assign rd.req_valid = core_pend || dma_rd_valid;
  assign rd.req_addr  = grant_core ? issue_addr : dma_rd_addr;
  assign rd.req_owner = grant_core ? owner_core : owner_dma;
  assign core_issue   = rd.req_ready && grant_core;

  //////////////////////////////
  // Response routing
  assign core_ret      = rd.resp_valid && (rd.resp_owner == owner_core);
  assign resp_valid    = rd.resp_valid && (rd.resp_owner == owner_dma);
  assign resp_data     = rd.resp_data;
  assign rd.resp_ready = (rd.resp_owner == owner_core) || resp_ready;

  // Stale core words after a core reset are dropped here
  assign csum_word  = rd.resp_data;
  assign csum_acc   = core_ret && (state == st_reading || state == st_draining);

  assign desc_ready = (state == st_idle) && (inflight == 2'd0);
  assign desc_fire  = desc_valid && desc_ready;
  assign csum_clear = desc_fire;

  assign odesc.slot  = cur.slot;
  assign odesc.len   = cur.len;
  assign odesc.csum  = csum;
  assign odesc_valid = (state == st_emitting);

  //////////////////////////////
  // FSM and word counters
  always_ff @(posedge clk) begin
    if (reset || core_reset) begin
      state      <= st_idle;
      issue_left <= '0;
      ret_left   <= '0;
      issue_addr <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (desc_fire) begin
            state      <= st_reading;
            issue_addr <= desc.addr;
            issue_left <= desc.len;
            ret_left   <= desc.len;
          end
        end
        st_reading: begin
          if (core_issue) begin
            issue_addr <= issue_addr + 1'b1;
            issue_left <= issue_left - 1'b1;
            if (issue_left == `PR_LEN_W'(1)) begin
              state <= st_draining;
            end
          end
        end
        st_draining: begin
          if (ret_left == '0) begin
            state <= st_emitting;
          end
        end
        st_emitting: begin
          if (odesc_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
      if (csum_acc) begin
        ret_left <= ret_left - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (desc_fire) begin
      cur <= desc;
    end
  end

  // Core reads in flight survive a core reset
  always_ff @(posedge clk) begin
    if (reset) begin
      inflight        <= 2'd0;
      last_core       <= 1'b0;
      core_reset_seen <= 1'b0;
    end else begin
      if (core_issue && !core_ret) begin
        inflight <= inflight + 2'd1;
      end else if (!core_issue && core_ret) begin
        inflight <= inflight - 2'd1;
      end
      if (rd.req_valid && rd.req_ready) begin
        last_core <= grant_core;
      end
      if (core_reset) begin
        core_reset_seen <= 1'b1;
      end else if (desc_fire) begin
        core_reset_seen <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    desc_fire |-> desc.len != '0)
    else $error("core_ctrl: zero length descriptor accepted");

  // Only leftovers of an aborted descriptor may come back while idle
  assert property (@(posedge clk) disable iff (reset)
    core_ret && state == st_idle |-> core_reset_seen)
    else $error("core_ctrl: unexpected core response while idle");

endmodule

`default_nettype wire

// File: csum_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "pr_macros.svh"

module csum_engine (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clear,
  input  logic                  acc_valid,
  input  logic [`PR_DATA_W-1:0] word,
  output logic [31:0]           sum
);

  logic [31:0] word_hi;
  logic [31:0] word_lo;

  assign word_hi = word[`PR_DATA_W-1:`PR_DATA_W/2];
  assign word_lo = word[`PR_DATA_W/2-1:0];

  // Both halves go in, wraps mod 2^32
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      sum <= 32'd0;
    end else if (acc_valid) begin
      sum <= sum + word_hi + word_lo;
    end
  end

endmodule

`default_nettype wire

// File: mem_rd_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "pr_macros.svh"

interface mem_rd_if import pr_pkg::*; ();

  logic                  req_valid;
  logic                  req_ready;
  logic [`PR_ADDR_W-1:0] req_addr;
  mem_owner_e            req_owner;

  logic                  resp_valid;
  logic [`PR_DATA_W-1:0] resp_data;
  mem_owner_e            resp_owner;
  logic                  resp_ready;

  modport ctrl (
    output req_valid, req_addr, req_owner, resp_ready,
    input  req_ready, resp_valid, resp_data, resp_owner
  );

  modport mem (
    input  req_valid, req_addr, req_owner, resp_ready,
    output req_ready, resp_valid, resp_data, resp_owner
  );

endinterface

`default_nettype wire

// File: pipe_reg.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic reset,

  input  T     s_data,
  input  logic s_valid,
  output logic s_ready,

  output T     m_data,
  output logic m_valid,
  input  logic m_ready
);

  T     skid_data;
  logic skid_valid;
  logic main_load;
  logic skid_load;

  // Output entry can take data when empty or draining
  assign main_load = !m_valid || m_ready;
  assign skid_load = s_valid && s_ready && !main_load;

  // Ready is low only with both entries full
  assign s_ready = !skid_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      m_valid    <= skid_valid || s_valid;
      skid_valid <= 1'b0;
    end else if (skid_load) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      m_data <= skid_valid ? skid_data : s_data;
    end
    if (skid_load) begin
      skid_data <= s_data;
    end
  end

  // A beat refused while both entries are full stays offered
  assert property (@(posedge clk) disable iff (reset)
    s_valid && !s_ready |=> s_valid && $stable(s_data))
    else $error("pipe_reg: input beat dropped while full");

endmodule

`default_nettype wire

// File: pkt_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "pr_macros.svh"

module pkt_mem import pr_pkg::*; (
  input  logic    clk,
  input  logic    reset,

  input  logic    wr_valid,
  input  dma_wr_t wr,

  mem_rd_if.mem   rd
);

  logic [`PR_DATA_W-1:0] mem [0:(1<<`PR_ADDR_W)-1];
  logic                  req_fire;

  // Keeps responses in order, one slot only
  assign rd.req_ready = !rd.resp_valid || rd.resp_ready;
  assign req_fire     = rd.req_valid && rd.req_ready;

  //////////////////////////////
  // Byte strobed write
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      for (int i = 0; i < `PR_STRB_W; i++) begin
        if (wr.strb[i]) begin
          mem[wr.addr][8*i +: 8] <= wr.data[8*i +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // Read port and response register
  always_ff @(posedge clk) begin
    if (reset) begin
      rd.resp_valid <= 1'b0;
    end else if (req_fire) begin
      rd.resp_valid <= 1'b1;
    end else if (rd.resp_ready) begin
      rd.resp_valid <= 1'b0;
    end
  end

  // Tag follows the data
  always_ff @(posedge clk) begin
    if (req_fire) begin
      rd.resp_data  <= mem[rd.req_addr];
      rd.resp_owner <= rd.req_owner;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    rd.resp_valid && !rd.resp_ready |=>
      rd.resp_valid && $stable(rd.resp_data) && $stable(rd.resp_owner))
    else $error("pkt_mem: response changed while stalled");

endmodule

`default_nettype wire

// File: pr_macros.svh
`ifndef PR_MACROS_SVH
`define PR_MACROS_SVH

// Memory word and byte strobes
`define PR_DATA_W 64
`define PR_STRB_W 8

// 1024 words
`define PR_ADDR_W 10

// Descriptor fields
`define PR_SLOT_W 4
`define PR_LEN_W  8

`endif

// File: pr_pkg.sv
`default_nettype none

`include "pr_macros.svh"

package pr_pkg;

  // Input descriptor, length counted in words
  typedef struct packed {
    logic [`PR_SLOT_W-1:0] slot;
    logic [`PR_ADDR_W-1:0] addr;
    logic [`PR_LEN_W-1:0]  len;
  } desc_t;

  typedef struct packed {
    logic [`PR_SLOT_W-1:0] slot;
    logic [`PR_LEN_W-1:0]  len;
    logic [31:0]           csum;
  } out_desc_t;

  // DMA write command
  typedef struct packed {
    logic [`PR_ADDR_W-1:0] addr;
    logic [`PR_DATA_W-1:0] data;
    logic [`PR_STRB_W-1:0] strb;
  } dma_wr_t;

  // Read tag, travels with request and response
  typedef enum logic {
    owner_dma  = 1'b0,
    owner_core = 1'b1
  } mem_owner_e;

endpackage

`default_nettype wire

// File: pr_wrapper.sv
`timescale 1ns/100ps
`default_nettype none

`include "pr_macros.svh"

module pr_wrapper import pr_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  core_reset,

  input  logic                  dma_wr_valid,
  input  logic [`PR_ADDR_W-1:0] dma_wr_addr,
  input  logic [`PR_DATA_W-1:0] dma_wr_data,
  input  logic [`PR_STRB_W-1:0] dma_wr_strb,
  output logic                  dma_wr_ready,

  input  logic                  dma_rd_valid,
  input  logic [`PR_ADDR_W-1:0] dma_rd_addr,
  output logic                  dma_rd_ready,

  output logic                  dma_resp_valid,
  output logic [`PR_DATA_W-1:0] dma_resp_data,
  input  logic                  dma_resp_ready,

  input  desc_t                 in_desc,
  input  logic                  in_desc_valid,
  output logic                  in_desc_ready,

  output out_desc_t             out_desc,
  output logic                  out_desc_valid,
  input  logic                  out_desc_ready
);

  //////////////////////////////
  // Registered resets
  logic reset_r;
  logic core_reset_r;
  logic desc_reset;

  always_ff @(posedge clk) begin
    reset_r      <= reset;
    core_reset_r <= core_reset;
  end

  assign desc_reset = reset_r || core_reset_r;

  //////////////////////////////
  // Boundary slices
  dma_wr_t wr_in;
  dma_wr_t wr_r;
  logic    wr_valid_r;

  assign wr_in.addr = dma_wr_addr;
  assign wr_in.data = dma_wr_data;
  assign wr_in.strb = dma_wr_strb;

  // Memory takes a write every cycle
  pipe_reg #(.T(dma_wr_t)) wr_reg (
    .clk(clk), .reset(reset_r),
    .s_data(wr_in), .s_valid(dma_wr_valid), .s_ready(dma_wr_ready),
    .m_data(wr_r), .m_valid(wr_valid_r), .m_ready(1'b1)
  );

  logic [`PR_ADDR_W-1:0] rd_addr_r;
  logic                  rd_valid_r;
  logic                  rd_ready_r;

  pipe_reg #(.T(logic [`PR_ADDR_W-1:0])) rd_reg (
    .clk(clk), .reset(reset_r),
    .s_data(dma_rd_addr), .s_valid(dma_rd_valid), .s_ready(dma_rd_ready),
    .m_data(rd_addr_r), .m_valid(rd_valid_r), .m_ready(rd_ready_r)
  );

  logic [`PR_DATA_W-1:0] resp_data_n;
  logic                  resp_valid_n;
  logic                  resp_ready_n;

  pipe_reg #(.T(logic [`PR_DATA_W-1:0])) resp_reg (
    .clk(clk), .reset(reset_r),
    .s_data(resp_data_n), .s_valid(resp_valid_n), .s_ready(resp_ready_n),
    .m_data(dma_resp_data), .m_valid(dma_resp_valid), .m_ready(dma_resp_ready)
  );

  desc_t in_desc_r;
  logic  in_desc_valid_r;
  logic  in_desc_ready_r;

  pipe_reg #(.T(desc_t)) in_desc_reg (
    .clk(clk), .reset(desc_reset),
    .s_data(in_desc), .s_valid(in_desc_valid), .s_ready(in_desc_ready),
    .m_data(in_desc_r), .m_valid(in_desc_valid_r), .m_ready(in_desc_ready_r)
  );

  out_desc_t out_desc_n;
  logic      out_desc_valid_n;
  logic      out_desc_ready_n;

  pipe_reg #(.T(out_desc_t)) out_desc_reg (
    .clk(clk), .reset(desc_reset),
    .s_data(out_desc_n), .s_valid(out_desc_valid_n), .s_ready(out_desc_ready_n),
    .m_data(out_desc), .m_valid(out_desc_valid), .m_ready(out_desc_ready)
  );

  //////////////////////////////
  // Core stand-in
  mem_rd_if rd_bus ();

  logic                  csum_clear;
  logic                  csum_acc;
  logic [`PR_DATA_W-1:0] csum_word;
  logic [31:0]           csum;

  pkt_mem mem_inst (
    .clk(clk),
    .reset(reset_r),
    .wr_valid(wr_valid_r),
    .wr(wr_r),
    .rd(rd_bus.mem)
  );

  csum_engine csum_inst (
    .clk(clk),
    .reset(reset_r),
    .clear(csum_clear),
    .acc_valid(csum_acc),
    .word(csum_word),
    .sum(csum)
  );

  core_ctrl ctrl_inst (
    .clk(clk),
    .reset(reset_r),
    .core_reset(core_reset_r),
    .desc(in_desc_r),
    .desc_valid(in_desc_valid_r),
    .desc_ready(in_desc_ready_r),
    .dma_rd_valid(rd_valid_r),
    .dma_rd_addr(rd_addr_r),
    .dma_rd_ready(rd_ready_r),
    .resp_valid(resp_valid_n),
    .resp_data(resp_data_n),
    .resp_ready(resp_ready_n),
    .csum_clear(csum_clear),
    .csum_acc(csum_acc),
    .csum_word(csum_word),
    .csum(csum),
    .odesc(out_desc_n),
    .odesc_valid(out_desc_valid_n),
    .odesc_ready(out_desc_ready_n),
    .rd(rd_bus.ctrl)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the testbench; exit status reports pass or fail
verilator --binary --timing --assert -Wno-fatal --top-module tb_pr_wrapper \
  -f sim.f -Mdir obj_dir -o tb_pr_wrapper_sim \
  && ./obj_dir/tb_pr_wrapper_sim \
  || exit 1

// File: sim.f
+incdir+.
pr_pkg.sv
mem_rd_if.sv
pipe_reg.sv
pkt_mem.sv
csum_engine.sv
core_ctrl.sv
pr_wrapper.sv
tb_pr_wrapper.sv

// File: tb_pr_wrapper.sv
`timescale 1ns/100ps
`default_nettype none

`include "pr_macros.svh"

module tb_pr_wrapper import pr_pkg::*; ();

  localparam int FILL_WRITES = 1 << `PR_ADDR_W;
  localparam int RAND_WRITES = 200;
  localparam int RAND_READS  = 100;
  localparam int CONC_READS  = 150;
  localparam int TAIL_READS  = 64;
  localparam int N_DESCS     = 16;
  localparam int N_ITEMS     = FILL_WRITES + RAND_WRITES + FILL_WRITES + RAND_READS
                               + CONC_READS + TAIL_READS;
  localparam int WATCHDOG_CYCLES = N_ITEMS * 16 + N_DESCS * 1500 + 2000;
  localparam int RESP_DEPTH  = 4096;
  localparam int DESC_DEPTH  = 64;

  logic                  clk;
  logic                  reset;
  logic                  core_reset;
  logic                  dma_wr_valid;
  logic [`PR_ADDR_W-1:0] dma_wr_addr;
  logic [`PR_DATA_W-1:0] dma_wr_data;
  logic [`PR_STRB_W-1:0] dma_wr_strb;
  logic                  dma_wr_ready;
  logic                  dma_rd_valid;
  logic [`PR_ADDR_W-1:0] dma_rd_addr;
  logic                  dma_rd_ready;
  logic                  dma_resp_valid;
  logic [`PR_DATA_W-1:0] dma_resp_data;
  logic                  dma_resp_ready;
  desc_t                 in_desc;
  logic                  in_desc_valid;
  logic                  in_desc_ready;
  out_desc_t             out_desc;
  logic                  out_desc_valid;
  logic                  out_desc_ready;

  // Stimulus mode flags
  logic quiet_phase;
  logic resp_rand;
  logic desc_rand;
  logic desc_hold;
  logic core_reset_phase;
  logic aborted_window;
  logic drop_desc;

  // Reference models and expected queues
  logic [`PR_DATA_W-1:0] model_mem [0:(1<<`PR_ADDR_W)-1];
  logic [`PR_DATA_W-1:0] resp_exp [0:RESP_DEPTH-1];
  out_desc_t             desc_exp [0:DESC_DEPTH-1];
  int                    resp_wr_ptr;
  int                    resp_rd_ptr;
  int                    desc_wr_ptr;
  int                    desc_rd_ptr;
  logic [`PR_DATA_W-1:0] resp_head;
  out_desc_t             desc_head;
  logic [`PR_DATA_W-1:0] resp_data_prev;
  out_desc_t             out_desc_prev;

  assign resp_head = resp_exp[resp_rd_ptr % RESP_DEPTH];
  assign desc_head = desc_exp[desc_rd_ptr % DESC_DEPTH];

  pr_wrapper uut (
    .clk(clk), .reset(reset), .core_reset(core_reset),
    .dma_wr_valid(dma_wr_valid), .dma_wr_addr(dma_wr_addr),
    .dma_wr_data(dma_wr_data), .dma_wr_strb(dma_wr_strb), .dma_wr_ready(dma_wr_ready),
    .dma_rd_valid(dma_rd_valid), .dma_rd_addr(dma_rd_addr), .dma_rd_ready(dma_rd_ready),
    .dma_resp_valid(dma_resp_valid), .dma_resp_data(dma_resp_data),
    .dma_resp_ready(dma_resp_ready),
    .in_desc(in_desc), .in_desc_valid(in_desc_valid), .in_desc_ready(in_desc_ready),
    .out_desc(out_desc), .out_desc_valid(out_desc_valid), .out_desc_ready(out_desc_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // Sum of both 32-bit halves over len words with the address wrapping
  function automatic logic [31:0] model_csum(input logic [`PR_ADDR_W-1:0] addr,
                                             input logic [`PR_LEN_W-1:0] len);
    logic [31:0]           sum;
    logic [`PR_ADDR_W-1:0] a;
    logic [`PR_DATA_W-1:0] w;
    sum = 32'd0;
    a   = addr;
    for (int i = 0; i < int'(len); i++) begin
      w   = model_mem[a];
      sum = sum + w[63:32] + w[31:0];
      a   = a + 1'b1;
    end
    return sum;
  endfunction

  function automatic logic [`PR_DATA_W-1:0] fill_word(input int a);
    return {32'h9e37_79b9 * (a + 1), ~(32'h85eb_ca6b * a) ^ a};
  endfunction

  //////////////////////////////
  // Models follow the accepted transfers
  always @(posedge clk) begin
    if (!reset) begin
      if (dma_wr_valid && dma_wr_ready) begin
        for (int i = 0; i < `PR_STRB_W; i++) begin
          if (dma_wr_strb[i]) begin
            model_mem[dma_wr_addr][8*i +: 8] <= dma_wr_data[8*i +: 8];
          end
        end
      end
      if (dma_rd_valid && dma_rd_ready) begin
        resp_exp[resp_wr_ptr % RESP_DEPTH] <= model_mem[dma_rd_addr];
        resp_wr_ptr <= resp_wr_ptr + 1;
      end
      if (dma_resp_valid && dma_resp_ready) begin
        resp_rd_ptr <= resp_rd_ptr + 1;
      end
      if (in_desc_valid && in_desc_ready) begin
        desc_exp[desc_wr_ptr % DESC_DEPTH] <= '{slot: in_desc.slot, len: in_desc.len,
                                               csum: model_csum(in_desc.addr, in_desc.len)};
        desc_wr_ptr <= desc_wr_ptr + 1;
      end
      if (drop_desc) begin
        desc_rd_ptr <= desc_wr_ptr;
      end else if (out_desc_valid && out_desc_ready) begin
        desc_rd_ptr <= desc_rd_ptr + 1;
      end
    end
    resp_data_prev <= dma_resp_data;
    out_desc_prev  <= out_desc;
  end

  //////////////////////////////
  // Checks
  quiet_resp: assert property (@(posedge clk) quiet_phase |-> !dma_resp_valid)
    else begin
      $display("FAIL %0t dma_resp_valid expected 0 got %b", $time, $sampled(dma_resp_valid));
      abort_run();
    end

  quiet_desc: assert property (@(posedge clk) quiet_phase || aborted_window |-> !out_desc_valid)
    else begin
      $display("FAIL %0t out_desc_valid expected 0 got %b", $time, $sampled(out_desc_valid));
      abort_run();
    end

  resp_expected: assert property (@(posedge clk) disable iff (reset)
    dma_resp_valid && dma_resp_ready |-> resp_rd_ptr != resp_wr_ptr)
    else begin
      $display("Read response arrived with no read outstanding at %0t", $time);
      abort_run();
    end

  resp_data_ok: assert property (@(posedge clk) disable iff (reset)
    dma_resp_valid && dma_resp_ready |-> dma_resp_data == resp_head)
    else begin
      $display("FAIL %0t dma_resp_data expected %h got %h", $time,
               $sampled(resp_head), $sampled(dma_resp_data));
      abort_run();
    end

  resp_held: assert property (@(posedge clk) disable iff (reset)
    dma_resp_valid && !dma_resp_ready |=> dma_resp_valid && dma_resp_data == resp_data_prev)
    else begin
      $display("FAIL %0t dma_resp_data expected %h got %h", $time,
               $sampled(resp_data_prev), $sampled(dma_resp_data));
      abort_run();
    end

  desc_expected: assert property (@(posedge clk) disable iff (reset)
    out_desc_valid && out_desc_ready |-> desc_rd_ptr != desc_wr_ptr)
    else begin
      $display("Output descriptor arrived with no descriptor outstanding at %0t", $time);
      abort_run();
    end

  desc_ok: assert property (@(posedge clk) disable iff (reset)
    out_desc_valid && out_desc_ready |-> out_desc == desc_head)
    else begin
      $display("FAIL %0t out_desc expected %h got %h", $time,
               $sampled(desc_head), $sampled(out_desc));
      abort_run();
    end

  desc_held: assert property (@(posedge clk) disable iff (reset || core_reset_phase)
    out_desc_valid && !out_desc_ready |=> out_desc_valid && out_desc == out_desc_prev)
    else begin
      $display("FAIL %0t out_desc expected %h got %h", $time,
               $sampled(out_desc_prev), $sampled(out_desc));
      abort_run();
    end

  //////////////////////////////
  // Stimulus tasks
  task automatic write_word(input logic [`PR_ADDR_W-1:0] addr,
                            input logic [`PR_DATA_W-1:0] data,
                            input logic [`PR_STRB_W-1:0] strb);
    dma_wr_valid = 1'b1;
    dma_wr_addr  = addr;
    dma_wr_data  = data;
    dma_wr_strb  = strb;
    while (!dma_wr_ready) step();
    step();
    dma_wr_valid = 1'b0;
  endtask

  task automatic read_word(input logic [`PR_ADDR_W-1:0] addr);
    dma_rd_valid = 1'b1;
    dma_rd_addr  = addr;
    while (!dma_rd_ready) step();
    step();
    dma_rd_valid = 1'b0;
  endtask

  task automatic send_desc(input int slot, input int addr, input int len);
    in_desc_valid = 1'b1;
    in_desc.slot  = slot[`PR_SLOT_W-1:0];
    in_desc.addr  = addr[`PR_ADDR_W-1:0];
    in_desc.len   = len[`PR_LEN_W-1:0];
    while (!in_desc_ready) step();
    step();
    in_desc_valid = 1'b0;
  endtask

  task automatic send_random_desc();
    send_desc($urandom_range(0, 15), $urandom_range(0, 1023), $urandom_range(1, 64));
  endtask

  task automatic wait_drained();
    while (resp_rd_ptr != resp_wr_ptr || desc_rd_ptr != desc_wr_ptr) step();
  endtask

  // Output side ready patterns
  initial begin
    dma_resp_ready = 1'b1;
    out_desc_ready = 1'b1;
    forever begin
      step();
      dma_resp_ready = resp_rand ? ($urandom_range(0, 3) != 0) : 1'b1;
      out_desc_ready = desc_hold ? 1'b0 : (desc_rand ? ($urandom_range(0, 1) == 1) : 1'b1);
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired, the run hung waiting for the DUT");
    abort_run();
  end

  initial begin
    void'($urandom(32'h3f11));
    reset            = 1'b1;
    core_reset       = 1'b0;
    dma_wr_valid     = 1'b0;
    dma_wr_addr      = '0;
    dma_wr_data      = '0;
    dma_wr_strb      = '0;
    dma_rd_valid     = 1'b0;
    dma_rd_addr      = '0;
    in_desc          = '0;
    in_desc_valid    = 1'b0;
    quiet_phase      = 1'b0;
    resp_rand        = 1'b0;
    desc_rand        = 1'b0;
    desc_hold        = 1'b0;
    core_reset_phase = 1'b0;
    aborted_window   = 1'b0;
    drop_desc        = 1'b0;
    resp_wr_ptr      = 0;
    resp_rd_ptr      = 0;
    desc_wr_ptr      = 0;
    desc_rd_ptr      = 0;
    repeat (4) step();
    quiet_phase = 1'b1;
    repeat (12) step();
    reset = 1'b0;
    repeat (8) step();
    quiet_phase = 1'b0;

    // Full fill and then strobed overwrites
    for (int a = 0; a < FILL_WRITES; a++) write_word(a, fill_word(a), '1);
    for (int i = 0; i < RAND_WRITES; i++) begin
      write_word($urandom_range(0, 1023), {$urandom, $urandom}, $urandom_range(0, 255));
    end
    repeat (4) step();

    resp_rand = 1'b1;
    for (int a = 0; a < FILL_WRITES; a++) read_word(a);
    for (int i = 0; i < RAND_READS; i++) read_word($urandom_range(0, 1023));
    wait_drained();

    //////////////////////////////
    // Descriptors including some that wrap
    desc_rand = 1'b1;
    for (int i = 0; i < 8; i++) send_random_desc();
    send_desc(3, 1020, 10);
    send_desc(12, 1000, 255);
    wait_drained();

    fork
      for (int i = 0; i < 4; i++) send_random_desc();
      for (int i = 0; i < CONC_READS; i++) read_word($urandom_range(0, 1023));
    join
    wait_drained();

    //////////////////////////////
    // Core reset in the middle of a descriptor
    desc_hold        = 1'b1;
    core_reset_phase = 1'b1;
    send_desc(9, 100, 200);
    repeat (12) step();
    core_reset = 1'b1;
    repeat (2) step();
    core_reset = 1'b0;
    drop_desc  = 1'b1;
    step();
    drop_desc = 1'b0;
    repeat (4) step();
    aborted_window = 1'b1;
    repeat (300) step();
    aborted_window   = 1'b0;
    core_reset_phase = 1'b0;
    desc_hold        = 1'b0;
    send_desc(5, 1010, 40);
    for (int i = 0; i < TAIL_READS; i++) read_word(i * 16);
    wait_drained();

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
